// File: src/glb_pkg.sv
// Widths, packet structs and register encodings shared by every block of the global buffer tile
package glb_pkg;

    // Word and address sizes
    localparam int DATA_WIDTH      = 16;
    localparam int BANK_ADDR_WIDTH = 8;
    // Default bank count, overridden from the tile top level
    localparam int BANKS_PER_TILE  = 2;
    // Upper address bits that pick the bank
    localparam int BANK_SEL_WIDTH  = (BANKS_PER_TILE > 1) ? $clog2(BANKS_PER_TILE) : 1;
    localparam int ADDR_WIDTH      = BANK_ADDR_WIDTH + BANK_SEL_WIDTH;

    // Write request
    typedef struct packed {
        logic                  wr_en;
        logic [ADDR_WIDTH-1:0] wr_addr;
        logic [DATA_WIDTH-1:0] wr_data;
    } wr_packet_t;

    // Read request
    typedef struct packed {
        logic                  rd_en;
        logic [ADDR_WIDTH-1:0] rd_addr;
    } rdrq_packet_t;

    // Read response, valid one cycle after the request
    typedef struct packed {
        logic                  rd_data_valid;
        logic [DATA_WIDTH-1:0] rd_data;
    } rdrs_packet_t;

    // Transfer description for either DMA
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] start_addr;
        logic [ADDR_WIDTH-1:0] num_words;
    } dma_header_t;

    typedef enum logic {
        DMA_OFF = 1'b0,
        DMA_ON  = 1'b1
    } dma_mode_e;

    // Config register map, codes 6 and 7 unused
    typedef enum logic [2:0] {
        CFG_ST_START = 3'd0,
        CFG_ST_COUNT = 3'd1,
        CFG_ST_MODE  = 3'd2,
        CFG_LD_START = 3'd3,
        CFG_LD_COUNT = 3'd4,
        CFG_LD_MODE  = 3'd5
    } cfg_reg_e;

endpackage

// File: src/glb_bank.sv
// Single SRAM bank of the tile, written and read through packets coming from the switch
`timescale 1ns/1ps

module glb_bank (
    input  logic                  clk,
    input  logic                  rst,
    input  glb_pkg::wr_packet_t   wr_packet,
    input  glb_pkg::rdrq_packet_t rdrq_packet,
    output glb_pkg::rdrs_packet_t rdrs_packet
);
    import glb_pkg::*;

    // Storage, no reset
    logic [DATA_WIDTH-1:0] mem [2**BANK_ADDR_WIDTH];

    // Registered read port
    logic [DATA_WIDTH-1:0] rd_data_q;
    logic                  rd_valid_q;

    // Only the low bits matter here, switch already stripped the bank select
    always_ff @(posedge clk) begin
        if (wr_packet.wr_en) begin
            mem[wr_packet.wr_addr[BANK_ADDR_WIDTH-1:0]] <= wr_packet.wr_data;
        end
    end

    // Same-cycle write to the same word is not visible yet, old data comes out
    always_ff @(posedge clk) begin
        if (rdrq_packet.rd_en) begin
            rd_data_q <= mem[rdrq_packet.rd_addr[BANK_ADDR_WIDTH-1:0]];
        end
    end

    // Valid flag follows the enable by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rdrq_packet.rd_en;
        end
    end

    assign rdrs_packet.rd_data_valid = rd_valid_q;
    assign rdrs_packet.rd_data       = rd_data_q;

endmodule

// File: src/glb_core_switch.sv
// Packet switch of the tile: picks a winner per path, steers it to one bank, routes responses back
`timescale 1ns/1ps

module glb_core_switch #(
    parameter int banks = glb_pkg::BANKS_PER_TILE
) (
    input  logic                  clk,
    input  logic                  rst,
    input  glb_pkg::wr_packet_t   wr_packet_pr2sw,
    input  glb_pkg::wr_packet_t   wr_packet_d2sw,
    input  glb_pkg::rdrq_packet_t rdrq_packet_pr2sw,
    input  glb_pkg::rdrq_packet_t rdrq_packet_d2sw,
    output glb_pkg::rdrs_packet_t rdrs_packet_sw2pr,
    output glb_pkg::rdrs_packet_t rdrs_packet_sw2d,
    output glb_pkg::wr_packet_t   wr_packet_sw2b [banks],
    output glb_pkg::rdrq_packet_t rdrq_packet_sw2b [banks],
    input  glb_pkg::rdrs_packet_t rdrs_packet_b2sw_arr [banks]
);
    import glb_pkg::*;

    wr_packet_t                wr_win;
    rdrq_packet_t              rd_win;
    logic [BANK_SEL_WIDTH-1:0] wr_bank;
    logic [BANK_SEL_WIDTH-1:0] rd_bank;

    // Remembers who asked and which bank answers next cycle
    logic                      rd_to_dma_q;
    logic                      rd_to_proc_q;
    logic [BANK_SEL_WIDTH-1:0] rd_bank_q;
    rdrs_packet_t              rdrs_sel;

    // DMA has priority, a colliding processor request is lost
    assign wr_win  = wr_packet_d2sw.wr_en ? wr_packet_d2sw : wr_packet_pr2sw;
    assign rd_win  = rdrq_packet_d2sw.rd_en ? rdrq_packet_d2sw : rdrq_packet_pr2sw;
    assign wr_bank = wr_win.wr_addr[ADDR_WIDTH-1:BANK_ADDR_WIDTH];
    assign rd_bank = rd_win.rd_addr[ADDR_WIDTH-1:BANK_ADDR_WIDTH];

    // Same packet to all banks, enable only at the selected one
    for (genvar i = 0; i < banks; i++) begin : g_bank_port
        assign wr_packet_sw2b[i].wr_en   = wr_win.wr_en && (wr_bank == BANK_SEL_WIDTH'(i));
        assign wr_packet_sw2b[i].wr_addr = ADDR_WIDTH'(wr_win.wr_addr[BANK_ADDR_WIDTH-1:0]);
        assign wr_packet_sw2b[i].wr_data = wr_win.wr_data;
        assign rdrq_packet_sw2b[i].rd_en   = rd_win.rd_en && (rd_bank == BANK_SEL_WIDTH'(i));
        assign rdrq_packet_sw2b[i].rd_addr = ADDR_WIDTH'(rd_win.rd_addr[BANK_ADDR_WIDTH-1:0]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_to_dma_q  <= 1'b0;
            rd_to_proc_q <= 1'b0;
        end else begin
            rd_to_dma_q  <= rdrq_packet_d2sw.rd_en;
            rd_to_proc_q <= rdrq_packet_pr2sw.rd_en && !rdrq_packet_d2sw.rd_en;
        end
    end

    always_ff @(posedge clk) begin
        rd_bank_q <= rd_bank;
    end

    // Response of the bank read last cycle
    assign rdrs_sel = rdrs_packet_b2sw_arr[rd_bank_q];

    // Exactly one requester sees the valid
    assign rdrs_packet_sw2d.rd_data_valid  = rd_to_dma_q && rdrs_sel.rd_data_valid;
    assign rdrs_packet_sw2d.rd_data        = rdrs_sel.rd_data;
    assign rdrs_packet_sw2pr.rd_data_valid = rd_to_proc_q && rdrs_sel.rd_data_valid;
    assign rdrs_packet_sw2pr.rd_data       = rdrs_sel.rd_data;

endmodule

// File: src/glb_core_store_dma.sv
// Store DMA: writes the word stream from the array into consecutive tile addresses
`timescale 1ns/1ps

module glb_core_store_dma (
    input  logic                            clk,
    input  logic                            rst,
    input  glb_pkg::dma_header_t            st_header,
    input  glb_pkg::dma_mode_e              st_mode,
    input  logic                            strm_start_pulse,
    input  logic [glb_pkg::DATA_WIDTH-1:0]  stream_data_f2g,
    input  logic                            stream_data_valid_f2g,
    output glb_pkg::wr_packet_t             wr_packet,
    output logic                            done_pulse
);
    import glb_pkg::*;

    typedef enum logic {
        IDLE,
        RUN
    } state_e;

    state_e                state;
    logic [ADDR_WIDTH-1:0] addr_cnt;
    logic [ADDR_WIDTH-1:0] words_left;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            done_pulse <= 1'b0;
        end else begin
            done_pulse <= 1'b0;
            case (state)
                IDLE: begin
                    // Busy DMA never gets here, so late start pulses are dropped
                    if (strm_start_pulse && st_mode == DMA_ON) begin
                        if (st_header.num_words == '0) begin
                            // Empty transfer finishes right away
                            done_pulse <= 1'b1;
                        end else begin
                            state <= RUN;
                        end
                    end
                end
                RUN: begin
                    // Pulse lands one cycle after the last write
                    if (stream_data_valid_f2g && words_left == ADDR_WIDTH'(1)) begin
                        state      <= IDLE;
                        done_pulse <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Header sampled while idle, so config changes apply at the next start
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            addr_cnt   <= st_header.start_addr;
            words_left <= st_header.num_words;
        end else if (stream_data_valid_f2g) begin
            addr_cnt   <= addr_cnt + 1'b1;
            words_left <= words_left - 1'b1;
        end
    end

    // Write happens in the arrival cycle
    assign wr_packet.wr_en   = (state == RUN) && stream_data_valid_f2g;
    assign wr_packet.wr_addr = addr_cnt;
    assign wr_packet.wr_data = stream_data_f2g;

endmodule

// File: src/glb_core_load_dma.sv
// Load DMA: reads consecutive tile words and streams them out to the array
`timescale 1ns/1ps

module glb_core_load_dma (
    input  logic                            clk,
    input  logic                            rst,
    input  glb_pkg::dma_header_t            ld_header,
    input  glb_pkg::dma_mode_e              ld_mode,
    input  logic                            strm_start_pulse,
    output glb_pkg::rdrq_packet_t           rdrq_packet,
    input  glb_pkg::rdrs_packet_t           rdrs_packet,
    output logic [glb_pkg::DATA_WIDTH-1:0]  stream_data_g2f,
    output logic                            stream_data_valid_g2f,
    output logic                            done_pulse
);
    import glb_pkg::*;

    // DRAIN waits one cycle for the final response
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } state_e;

    state_e                state;
    logic [ADDR_WIDTH-1:0] addr_cnt;
    logic [ADDR_WIDTH-1:0] words_left;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            done_pulse <= 1'b0;
        end else begin
            // Last word is on the stream during DRAIN, done follows it
            done_pulse <= (state == DRAIN);
            case (state)
                IDLE: begin
                    if (strm_start_pulse && ld_mode == DMA_ON) begin
                        // Nothing to read, skip straight to the done pulse
                        if (ld_header.num_words == '0) begin
                            state <= DRAIN;
                        end else begin
                            state <= RUN;
                        end
                    end
                end
                RUN: begin
                    if (words_left == ADDR_WIDTH'(1)) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Header latched at start, one address per cycle while running
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            addr_cnt   <= ld_header.start_addr;
            words_left <= ld_header.num_words;
        end else if (state == RUN) begin
            addr_cnt   <= addr_cnt + 1'b1;
            words_left <= words_left - 1'b1;
        end
    end

    // One request per RUN cycle
    assign rdrq_packet.rd_en   = (state == RUN);
    assign rdrq_packet.rd_addr = addr_cnt;

    // Bank already registered the data, response goes out as it arrives
    // Never stalls, no back-pressure from the array
    assign stream_data_valid_g2f = (state != IDLE) && rdrs_packet.rd_data_valid;
    assign stream_data_g2f       = rdrs_packet.rd_data;

endmodule

// File: src/glb_core_cfg.sv
// Configuration registers of the tile, written by address, feeding headers and modes to both DMAs
`timescale 1ns/1ps

module glb_core_cfg (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cfg_wr_en,
    input  glb_pkg::cfg_reg_e               cfg_addr,
    input  logic [glb_pkg::DATA_WIDTH-1:0]  cfg_wr_data,
    output glb_pkg::dma_header_t            st_header,
    output glb_pkg::dma_mode_e              st_mode,
    output glb_pkg::dma_header_t            ld_header,
    output glb_pkg::dma_mode_e              ld_mode
);
    import glb_pkg::*;

    // Header fields take the low address bits of the write data
    logic [ADDR_WIDTH-1:0] wr_field;
    dma_mode_e             wr_mode;

    assign wr_field = cfg_wr_data[ADDR_WIDTH-1:0];
    // Mode is bit 0
    assign wr_mode  = dma_mode_e'(cfg_wr_data[0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            st_header <= '0;
            st_mode   <= DMA_OFF;
            ld_header <= '0;
            ld_mode   <= DMA_OFF;
        end else if (cfg_wr_en) begin
            case (cfg_addr)
                // Store side
                CFG_ST_START: st_header.start_addr <= wr_field;
                CFG_ST_COUNT: st_header.num_words  <= wr_field;
                CFG_ST_MODE:  st_mode              <= wr_mode;
                // Load side
                CFG_LD_START: ld_header.start_addr <= wr_field;
                CFG_LD_COUNT: ld_header.num_words  <= wr_field;
                CFG_LD_MODE:  ld_mode              <= wr_mode;
                // Unmapped codes leave every register alone
                default: begin
                end
            endcase
        end
    end

endmodule

// File: src/glb_core.sv
// Global buffer tile top level: banks, packet switch, store and load DMAs and their config block
`timescale 1ns/1ps

module glb_core #(
    parameter int BANKS_PER_TILE = glb_pkg::BANKS_PER_TILE
) (
    input  logic                            clk,
    input  logic                            rst,

    // Processor port
    input  glb_pkg::wr_packet_t             proc_wr,
    input  glb_pkg::rdrq_packet_t           proc_rdrq,
    output glb_pkg::rdrs_packet_t           proc_rdrs,

    // Array streams
    input  logic [glb_pkg::DATA_WIDTH-1:0]  stream_data_f2g,
    input  logic                            stream_data_valid_f2g,
    output logic [glb_pkg::DATA_WIDTH-1:0]  stream_data_g2f,
    output logic                            stream_data_valid_g2f,

    // Config writes
    input  logic                            cfg_wr_en,
    input  glb_pkg::cfg_reg_e               cfg_addr,
    input  logic [glb_pkg::DATA_WIDTH-1:0]  cfg_wr_data,

    input  logic                            strm_start_pulse,
    // Bit 0 store done, bit 1 load done
    output logic [1:0]                      interrupt_pulse
);
    import glb_pkg::*;

    // DMA setup
    dma_header_t  st_header;
    dma_mode_e    st_mode;
    dma_header_t  ld_header;
    dma_mode_e    ld_mode;

    // DMA to switch
    wr_packet_t   wr_packet_d2sw;
    rdrq_packet_t rdrq_packet_d2sw;
    rdrs_packet_t rdrs_packet_sw2d;
    logic         st_done_pulse;
    logic         ld_done_pulse;

    // Switch to banks
    wr_packet_t   wr_packet_sw2b [BANKS_PER_TILE];
    rdrq_packet_t rdrq_packet_sw2b [BANKS_PER_TILE];
    rdrs_packet_t rdrs_packet_b2sw_arr [BANKS_PER_TILE];

    for (genvar i = 0; i < BANKS_PER_TILE; i++) begin : g_bank
        glb_bank bank (
            .wr_packet   (wr_packet_sw2b[i]),
            .rdrq_packet (rdrq_packet_sw2b[i]),
            .rdrs_packet (rdrs_packet_b2sw_arr[i]),
            .*);
    end

    glb_core_switch #(.banks(BANKS_PER_TILE)) switch (
        .wr_packet_pr2sw   (proc_wr),
        .rdrq_packet_pr2sw (proc_rdrq),
        .rdrs_packet_sw2pr (proc_rdrs),
        .*);

    glb_core_store_dma store_dma (
        .wr_packet  (wr_packet_d2sw),
        .done_pulse (st_done_pulse),
        .*);

    glb_core_load_dma load_dma (
        .rdrq_packet (rdrq_packet_d2sw),
        .rdrs_packet (rdrs_packet_sw2d),
        .done_pulse  (ld_done_pulse),
        .*);

    glb_core_cfg cfg (.*);

    assign interrupt_pulse = {ld_done_pulse, st_done_pulse};

endmodule

// File: testbench/glb_model.svh
// Reference model for the tile testbench, included in the testbench module body: memory mirror and xorshift source
`ifndef GLB_MODEL_SVH
`define GLB_MODEL_SVH

localparam int          MODEL_WORDS = 2 ** ADDR_WIDTH;
localparam logic [31:0] RNG_SEED    = 32'h459d33df;

// Mirror of every write that reaches a bank
logic [DATA_WIDTH-1:0] model_mem [MODEL_WORDS];
logic [31:0]           rng_state = RNG_SEED;
// Words the load DMA should put on the stream, oldest first
logic [DATA_WIDTH-1:0] exp_stream [$];

// 32-bit xorshift with shifts 13, 17, 5
function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// Pick in 0 .. n-1
function automatic int rand_below(input int n);
    return int'(next_rand() % 32'(n));
endfunction

function automatic void mirror_write(input logic [ADDR_WIDTH-1:0] addr,
                                     input logic [DATA_WIDTH-1:0] data);
    model_mem[addr] = data;
endfunction

function automatic logic [DATA_WIDTH-1:0] stored_word(input logic [ADDR_WIDTH-1:0] addr);
    return model_mem[addr];
endfunction

// Load DMA reads base upward, one word per cycle
function automatic void expect_region(input int base, input int count);
    int k;
    exp_stream.delete();
    for (k = 0; k < count; k++) begin
        exp_stream.push_back(model_mem[ADDR_WIDTH'(base + k)]);
    end
endfunction

`endif

// File: testbench/glb_core_tb.sv
// Simulation top that checks processor traffic and DMA transfers of the tile against a model
`timescale 1ns/1ps

module glb_core_tb;
    import glb_pkg::*;

    `include "glb_model.svh"

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int IDLE_CYCLES   = 10;
    localparam int RANDOM_OPS    = 200;
    localparam int MAX_COUNT     = 40;
    localparam int EXTRA_WORDS   = 4;
    localparam int OFF_CYCLES    = 30;
    // Store stream has gaps of about four cycles per word at worst
    localparam int DMA_RUN_LIMIT = 4 * MAX_COUNT + 16;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + MODEL_WORDS + RANDOM_OPS
        + 4 * (DMA_RUN_LIMIT + 12) + 4 * (MAX_COUNT + EXTRA_WORDS + 1) + OFF_CYCLES + 100;

    logic                  clk;
    logic                  rst;
    wr_packet_t            proc_wr;
    rdrq_packet_t          proc_rdrq;
    rdrs_packet_t          proc_rdrs;
    logic [DATA_WIDTH-1:0] stream_data_f2g;
    logic                  stream_data_valid_f2g;
    logic [DATA_WIDTH-1:0] stream_data_g2f;
    logic                  stream_data_valid_g2f;
    logic                  cfg_wr_en;
    cfg_reg_e              cfg_addr;
    logic [DATA_WIDTH-1:0] cfg_wr_data;
    logic                  strm_start_pulse;
    logic [1:0]            interrupt_pulse;

    int err_cnt    = 0;
    int cycle_cnt  = 0;
    int st_irq_cnt = 0;
    int ld_irq_cnt = 0;
    // Regions of the current transfers
    int st_base;
    int st_count;
    int ld_base;
    int ld_count;

    glb_core #(.BANKS_PER_TILE(BANKS_PER_TILE)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d clock cycles without finishing", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // Interrupt pulses counted on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            st_irq_cnt <= st_irq_cnt + int'(interrupt_pulse[0]);
            ld_irq_cnt <= ld_irq_cnt + int'(interrupt_pulse[1]);
        end
    end

    task automatic report_error(input string msg);
        $display("** Error at %0d ns: %s", $time, msg);
        err_cnt++;
    endtask

    // Outputs sampled and inputs driven 1 ns into the cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_cfg(input cfg_reg_e addr, input int value);
        next_cycle();
        cfg_wr_en   = 1'b1;
        cfg_addr    = addr;
        cfg_wr_data = DATA_WIDTH'(value);
    endtask

    // Pipelined processor reads with each response due one cycle later
    task automatic read_back(input int base, input int count);
        logic [DATA_WIDTH-1:0] exp_data;
        int k;
        for (k = 0; k <= count; k++) begin
            next_cycle();
            cfg_wr_en = 1'b0;
            if (k > 0 && proc_rdrs.rd_data_valid !== 1'b1) begin
                report_error($sformatf("no read response for address %0d", base + k - 1));
            end else if (k > 0 && proc_rdrs.rd_data !== exp_data) begin
                report_error($sformatf("address %0d read %h, expected %h",
                                       base + k - 1, proc_rdrs.rd_data, exp_data));
            end
            proc_rdrq = '0;
            if (k < count) begin
                proc_rdrq = '{1'b1, ADDR_WIDTH'(base + k)};
                exp_data  = stored_word(ADDR_WIDTH'(base + k));
            end
        end
    endtask

    // One start pulse followed by store feed and load stream checks cycle by cycle
    task automatic run_dmas(input bit do_st, input bit do_ld);
        int                    j;
        int                    sent;
        int                    last_wr;
        int                    st_before;
        int                    ld_before;
        bit                    st_done;
        bit                    ld_done;
        bit                    exp_valid;
        logic [DATA_WIDTH-1:0] word;
        j         = 0;
        sent      = 0;
        last_wr   = -1;
        st_done   = !do_st;
        ld_done   = !do_ld;
        st_before = st_irq_cnt;
        ld_before = ld_irq_cnt;
        if (do_ld) begin
            expect_region(ld_base, ld_count);
        end
        next_cycle();
        cfg_wr_en        = 1'b0;
        strm_start_pulse = 1'b1;
        while (!(st_done && ld_done) && j < DMA_RUN_LIMIT) begin
            next_cycle();
            j++;
            strm_start_pulse = 1'b0;
            // Load words due from start+2 to start+count+1
            exp_valid = do_ld && j >= 2 && j <= ld_count + 1;
            if (stream_data_valid_g2f !== exp_valid) begin
                report_error($sformatf("stream valid %b, expected %b, %0d cycles after start",
                                       stream_data_valid_g2f, exp_valid, j));
            end else if (exp_valid && stream_data_g2f !== exp_stream[0]) begin
                report_error($sformatf("stream word %h, expected %h", stream_data_g2f,
                                       exp_stream[0]));
            end
            if (exp_valid) begin
                void'(exp_stream.pop_front());
            end
            if (interrupt_pulse[1] !== (do_ld && j == ld_count + 2)) begin
                report_error($sformatf("load done %b, %0d cycles after start",
                                       interrupt_pulse[1], j));
            end
            // Store done one cycle after its last write
            if (interrupt_pulse[0] !== (do_st && last_wr >= 0 && j == last_wr + 1)) begin
                report_error($sformatf("store done %b, %0d cycles after start",
                                       interrupt_pulse[0], j));
            end
            ld_done = ld_done || j == ld_count + 2;
            st_done = st_done || (last_wr >= 0 && j == last_wr + 1);
            stream_data_valid_f2g = 1'b0;
            if (do_st && sent < st_count && rand_below(4) != 0) begin
                word                  = DATA_WIDTH'(next_rand());
                stream_data_valid_f2g = 1'b1;
                stream_data_f2g       = word;
                mirror_write(ADDR_WIDTH'(st_base + sent), word);
                sent++;
                if (sent == st_count) begin
                    last_wr = j;
                end
            end
        end
        stream_data_valid_f2g = 1'b0;
        if (!(st_done && ld_done)) begin
            $display("DMA transfer did not finish within %0d cycles", DMA_RUN_LIMIT);
            err_cnt++;
        end
        repeat (3) next_cycle();
        if (st_irq_cnt - st_before != int'(do_st) || ld_irq_cnt - ld_before != int'(do_ld)) begin
            report_error($sformatf("interrupt counts store %0d load %0d, expected %0d %0d",
                                   st_irq_cnt - st_before, ld_irq_cnt - ld_before, do_st, do_ld));
        end
    endtask

    initial begin
        logic                  pend;
        logic [DATA_WIDTH-1:0] pend_data;
        logic [ADDR_WIDTH-1:0] rd_addr;
        logic [ADDR_WIDTH-1:0] wr_addr;
        logic [DATA_WIDTH-1:0] word;
        int                    k;
        rst                   = 1'b1;
        proc_wr               = '0;
        proc_rdrq             = '0;
        stream_data_f2g       = '0;
        stream_data_valid_f2g = 1'b0;
        cfg_wr_en             = 1'b0;
        cfg_addr              = CFG_ST_START;
        cfg_wr_data           = '0;
        strm_start_pulse      = 1'b0;
        pend                  = 1'b0;
        pend_data             = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // Quiet tile after reset
        for (k = 0; k < IDLE_CYCLES; k++) begin
            next_cycle();
            if (stream_data_valid_g2f !== 1'b0 || proc_rdrs.rd_data_valid !== 1'b0 ||
                interrupt_pulse !== 2'b00) begin
                report_error("valid or interrupt high with no stimulus");
            end
        end

        // Known data in both banks
        for (k = 0; k < MODEL_WORDS; k++) begin
            next_cycle();
            word    = DATA_WIDTH'(next_rand());
            proc_wr = '{1'b1, ADDR_WIDTH'(k), word};
            mirror_write(ADDR_WIDTH'(k), word);
        end

        // Random reads and writes with some writes hitting the word read in the same cycle
        for (k = 0; k <= RANDOM_OPS; k++) begin
            next_cycle();
            if (pend && proc_rdrs.rd_data_valid !== 1'b1) begin
                report_error("processor read response missing");
            end else if (pend && proc_rdrs.rd_data !== pend_data) begin
                report_error($sformatf("read %h, expected %h", proc_rdrs.rd_data, pend_data));
            end else if (!pend && proc_rdrs.rd_data_valid !== 1'b0) begin
                report_error("read response without a request");
            end
            proc_wr   = '0;
            proc_rdrq = '0;
            pend      = 1'b0;
            rd_addr   = ADDR_WIDTH'(next_rand());
            if (k < RANDOM_OPS && rand_below(3) != 0) begin
                proc_rdrq = '{1'b1, rd_addr};
                pend      = 1'b1;
                // Old value expected even if written now
                pend_data = stored_word(rd_addr);
            end
            if (k < RANDOM_OPS && rand_below(2) == 0) begin
                wr_addr = (pend && rand_below(2) == 0) ? rd_addr : ADDR_WIDTH'(next_rand());
                word    = DATA_WIDTH'(next_rand());
                proc_wr = '{1'b1, wr_addr, word};
                mirror_write(wr_addr, word);
            end
        end

        // Store DMA alone followed by words past the count
        st_count = 8 + rand_below(MAX_COUNT - 7);
        st_base  = rand_below(MODEL_WORDS - st_count - EXTRA_WORDS);
        write_cfg(CFG_ST_START, st_base);
        write_cfg(CFG_ST_COUNT, st_count);
        write_cfg(CFG_ST_MODE, 1);
        run_dmas(1'b1, 1'b0);
        for (k = 0; k < EXTRA_WORDS; k++) begin
            next_cycle();
            stream_data_valid_f2g = 1'b1;
            stream_data_f2g       = DATA_WIDTH'(next_rand());
        end
        next_cycle();
        stream_data_valid_f2g = 1'b0;
        read_back(st_base, st_count + EXTRA_WORDS);

        // Load DMA alone with the store DMA off so it does not hang in RUN
        ld_count = 8 + rand_below(MAX_COUNT - 7);
        ld_base  = rand_below(MODEL_WORDS - ld_count);
        write_cfg(CFG_ST_MODE, 0);
        write_cfg(CFG_LD_START, ld_base);
        write_cfg(CFG_LD_COUNT, ld_count);
        write_cfg(CFG_LD_MODE, 1);
        run_dmas(1'b0, 1'b1);

        // Both DMAs with the store in bank 0 and the load in bank 1
        st_count = 8 + rand_below(MAX_COUNT - 7);
        st_base  = rand_below(MODEL_WORDS / 2 - st_count);
        ld_count = 8 + rand_below(MAX_COUNT - 7);
        ld_base  = MODEL_WORDS / 2 + rand_below(MODEL_WORDS / 2 - ld_count);
        write_cfg(CFG_ST_START, st_base);
        write_cfg(CFG_ST_COUNT, st_count);
        write_cfg(CFG_ST_MODE, 1);
        write_cfg(CFG_LD_START, ld_base);
        write_cfg(CFG_LD_COUNT, ld_count);
        run_dmas(1'b1, 1'b1);
        read_back(st_base, st_count);

        // Both modes off while the stream is still fed
        write_cfg(CFG_ST_MODE, 0);
        write_cfg(CFG_LD_MODE, 0);
        next_cycle();
        cfg_wr_en        = 1'b0;
        strm_start_pulse = 1'b1;
        for (k = 0; k < OFF_CYCLES; k++) begin
            next_cycle();
            strm_start_pulse      = 1'b0;
            if (stream_data_valid_g2f !== 1'b0 || interrupt_pulse !== 2'b00) begin
                report_error("output from a DMA whose mode is off");
            end
            stream_data_valid_f2g = 1'(rand_below(2));
            stream_data_f2g       = DATA_WIDTH'(next_rand());
        end
        next_cycle();
        stream_data_valid_f2g = 1'b0;
        read_back(st_base, st_count);

        $display("Checks done, %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: glb_core.f
+incdir+testbench
src/glb_pkg.sv
src/glb_bank.sv
src/glb_core_switch.sv
src/glb_core_store_dma.sv
src/glb_core_load_dma.sv
src/glb_core_cfg.sv
src/glb_core.sv
testbench/glb_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module glb_core_tb -f glb_core.f \
    --Mdir obj_dir -o glb_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/glb_core_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
